/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dmem_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_dmem_ctrl.sv */
// Data memory access block testbench
`default_nettype none

module tb_dmem_ctrl;
  import dmem_pkg::*;

  localparam int XLEN         = 32;
  localparam int PMA_CNT      = 3;
  localparam int PMP_CNT      = 4;
  localparam int RESET_CYCLES = 16;
  localparam int N_ACCESS     = 30;
  // Worst access takes 12 cycles with both bus delays at 3
  localparam int WATCHDOG     = (RESET_CYCLES + 4 + N_ACCESS * 12) * 10;
  // Bus answers this word with an error
  localparam logic [31:0] ERR_ADR = 32'h0000_0FF0;
  localparam logic WR = 1'b1;
  localparam logic RD = 1'b0;

  typedef enum logic [1:0] {PASS, REFUSE, MISALIGN, BUS_ERR} outcome_t;

  logic            clk_i;
  logic            rst_n_i;
  pmacfg_t         pma_cfg_i [PMA_CNT];
  logic [XLEN-1:0] pma_adr_i [PMA_CNT];
  pmpcfg_t         pmp_cfg_i [PMP_CNT];
  logic [XLEN-1:0] pmp_adr_i [PMP_CNT];
  prv_t            prv_i;
  logic            mem_req_i;
  logic [XLEN-1:0] mem_adr_i;
  size_t           mem_size_i;
  logic            mem_we_i;
  logic [XLEN-1:0] mem_d_i;
  logic            mem_lock_i;
  logic [XLEN-1:0] mem_q_o;
  logic            mem_ack_o;
  logic            mem_err_o;
  logic            mem_misaligned_o;
  logic            biu_stb_o;
  logic            biu_stb_ack_i;
  logic [XLEN-1:0] biu_adri_o;
  size_t           biu_size_o;
  logic            biu_we_o;
  logic            biu_lock_o;
  prot_t           biu_prot_o;
  logic [XLEN-1:0] biu_d_o;
  logic [XLEN-1:0] biu_q_i;
  logic            biu_ack_i;
  logic            biu_err_i;

  // Expected outcome of the access in flight
  logic            exp_ok;
  logic            exp_mis;
  logic            exp_bus;
  logic            exp_chk;
  logic [31:0]     exp_q;
  logic [31:0]     exp_adr;
  size_t           exp_size;
  logic            exp_we;
  logic            exp_lock;
  logic [2:0]      exp_prot;

  logic [31:0]     mem [4096];
  logic [31:0]     rng_stim;
  logic [31:0]     rng_bus;
  string           test_name;
  int              errors;
  int              failed_tests;
  int              tests_run;
  int              test_start_errors;

  dmem_ctrl #(
    .XLEN    ( XLEN    ),
    .PMA_CNT ( PMA_CNT ),
    .PMP_CNT ( PMP_CNT ) )
  i_dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Power-on contents unique to each word address
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ 32'h0000_006B;
  endfunction

  // Byte lanes touched by an access
  function automatic logic [3:0] lane_mask(input size_t size, input logic [1:0] off);
    logic [3:0] m;
    case (size)
      SIZE_BYTE: m = 4'b0001;
      SIZE_HALF: m = 4'b0011;
      default:   m = 4'b1111;
    endcase
    return m << off;
  endfunction

  task automatic report_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_event(input string what);
    $display("ERROR in %s: %s", test_name, what);
    errors++;
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  // Half a cycle lets the last assertions of the test report
  task automatic end_test();
    @(negedge clk_i);
    tests_run++;
    if (errors == test_start_errors)
      $display("test %s: pass", test_name);
    else
    begin
      $display("test %s: %0d errors", test_name, errors - test_start_errors);
      failed_tests++;
    end
  endtask

  // One CPU access held until the answer pulse
  task automatic run_access(input prv_t prv, input logic we, input size_t size,
                            input logic [31:0] adr, input logic [31:0] d,
                            input outcome_t outcome, input logic chk,
                            input logic [31:0] q);
    // Random lock flag per access
    rng_stim = xorshift32(rng_stim);
    @(posedge clk_i);
    prv_i      <= prv;
    mem_req_i  <= 1'b1;
    mem_adr_i  <= adr;
    mem_size_i <= size;
    mem_we_i   <= we;
    mem_d_i    <= d;
    mem_lock_i <= rng_stim[0];
    exp_ok     <= (outcome == PASS);
    exp_mis    <= (outcome == MISALIGN);
    exp_bus    <= (outcome == PASS) || (outcome == BUS_ERR);
    exp_chk    <= chk;
    exp_q      <= q;
    exp_adr    <= adr;
    exp_size   <= size;
    exp_we     <= we;
    exp_lock   <= rng_stim[0];
    // Data bit always set and privileged bit unless user mode
    exp_prot   <= (prv == PRV_U) ? 3'b001 : 3'b011;
    do
      @(posedge clk_i);
    while (!(mem_ack_o || mem_err_o));
    mem_req_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ack_o && exp_chk |-> mem_q_o == exp_q)
    else report_value("read data", $sampled(exp_q), $sampled(mem_q_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(biu_stb_o) |-> biu_adri_o == exp_adr)
    else report_value("strobe address", $sampled(exp_adr), $sampled(biu_adri_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(biu_stb_o) |-> biu_size_o == exp_size)
    else report_value("strobe size", $sampled(exp_size), $sampled(biu_size_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(biu_stb_o) |-> biu_we_o == exp_we)
    else report_value("strobe write flag", $sampled(exp_we), $sampled(biu_we_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(biu_stb_o) |-> biu_lock_o == exp_lock)
    else report_value("strobe lock", $sampled(exp_lock), $sampled(biu_lock_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(biu_stb_o) |-> biu_prot_o == exp_prot)
    else report_value("strobe protection", $sampled(exp_prot), $sampled(biu_prot_o));
  // Back-pressure keeps the transfer intact
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_stb_o && !biu_stb_ack_i |=> $stable(biu_adri_o) && $stable(biu_size_o) &&
      $stable(biu_we_o) && $stable(biu_lock_o) && $stable(biu_prot_o) &&
      $stable(biu_d_o))
    else report_event("strobe fields changed while the strobe waited");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) biu_stb_o |-> exp_bus)
    else report_event("a refused access reached the bus");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_i) && !exp_bus |=> mem_err_o)
    else report_event("refusal did not come one cycle after the request");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_i) && exp_bus |=> biu_stb_o)
    else report_event("strobe did not come one cycle after the request");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) mem_ack_o |-> exp_ok)
    else report_event("access was acknowledged but should have failed");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) mem_err_o |-> !exp_ok)
    else report_event("access failed but should have been acknowledged");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_err_o |-> mem_misaligned_o == exp_mis)
    else report_value("misaligned flag", $sampled(exp_mis), $sampled(mem_misaligned_o));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_misaligned_o |-> mem_err_o)
    else report_event("misaligned flag was raised without an error");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(mem_ack_o && mem_err_o))
    else report_event("ack and error were high together");

  ////////////////////////////////////////////////////////////////////////////
  // Clock, bus model, watchdog

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Random stall before strobe ack and before the answer
  initial
  begin : bus_model
    int          delay;
    logic [31:0] adr;
    logic [31:0] wdata;
    logic        we;
    logic [3:0]  lanes;
    forever
    begin
      @(posedge clk_i);
      if (biu_stb_o)
      begin
        rng_bus = xorshift32(rng_bus);
        delay   = int'(rng_bus[1:0]);
        repeat (delay) @(posedge clk_i);
        biu_stb_ack_i <= 1'b1;
        adr   = biu_adri_o;
        we    = biu_we_o;
        wdata = biu_d_o;
        lanes = lane_mask(biu_size_o, biu_adri_o[1:0]);
        @(posedge clk_i);
        biu_stb_ack_i <= 1'b0;
        rng_bus = xorshift32(rng_bus);
        delay   = int'(rng_bus[1:0]);
        repeat (delay) @(posedge clk_i);
        if (adr == ERR_ADR)
          biu_err_i <= 1'b1;
        else
        begin
          // Store data already sits in its byte lanes
          for (int b = 0; b < 4; b++)
            if (we && lanes[b])
              mem[adr[13:2]][8*b +: 8] = wdata[8*b +: 8];
          biu_ack_i <= 1'b1;
          biu_q_i   <= mem[adr[13:2]];
        end
        @(posedge clk_i);
        biu_ack_i <= 1'b0;
        biu_err_i <= 1'b0;
      end
    end
  end

  initial
  begin
    #(WATCHDOG);
    $display("timeout: the accesses did not finish in the expected time");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    logic [31:0] adr;
    logic [31:0] data;
    errors = 0;
    failed_tests = 0;
    tests_run = 0;
    rng_stim = 32'd69;
    rng_bus  = 32'd69;
    for (int i = 0; i < 4096; i++)
      mem[i] = fill_word(i * 4);
    // PMA regions RW, read-only, then RW with misaligned support
    pma_cfg_i[0] = '{r: 1'b1, w: 1'b1, mis_ok: 1'b0};
    pma_cfg_i[1] = '{r: 1'b1, w: 1'b0, mis_ok: 1'b0};
    pma_cfg_i[2] = '{r: 1'b1, w: 1'b1, mis_ok: 1'b1};
    pma_adr_i[0] = 32'h1000;
    pma_adr_i[1] = 32'h2000;
    pma_adr_i[2] = 32'h3000;
    // PMP grants region 0 to everyone and locks a read-only window at 0x2400
    pmp_cfg_i[0] = '{l: 1'b0, rsvd: 1'b0, tor: 1'b1, w: 1'b1, r: 1'b1};
    pmp_cfg_i[1] = '{l: 1'b0, rsvd: 1'b0, tor: 1'b0, w: 1'b0, r: 1'b0};
    pmp_cfg_i[2] = '{l: 1'b0, rsvd: 1'b0, tor: 1'b0, w: 1'b0, r: 1'b0};
    pmp_cfg_i[3] = '{l: 1'b1, rsvd: 1'b0, tor: 1'b1, w: 1'b0, r: 1'b1};
    pmp_adr_i[0] = 32'h1000;
    pmp_adr_i[1] = 32'h2000;
    pmp_adr_i[2] = 32'h2400;
    pmp_adr_i[3] = 32'h2800;
    prv_i = PRV_M;
    mem_req_i = 1'b0;
    mem_adr_i = '0;
    mem_size_i = SIZE_WORD;
    mem_we_i = 1'b0;
    mem_d_i = '0;
    mem_lock_i = 1'b0;
    biu_stb_ack_i = 1'b0;
    biu_q_i = '0;
    biu_ack_i = 1'b0;
    biu_err_i = 1'b0;
    exp_ok = 1'b0;
    exp_mis = 1'b0;
    exp_bus = 1'b0;
    exp_chk = 1'b0;
    exp_q = '0;
    exp_adr = '0;
    exp_size = SIZE_WORD;
    exp_we = 1'b0;
    exp_lock = 1'b0;
    exp_prot = '0;
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    begin_test("word store and load");
    for (int k = 0; k < 4; k++)
    begin
      rng_stim = xorshift32(rng_stim);
      adr      = 32'h200 + {22'd0, rng_stim[9:2], 2'b00};
      rng_stim = xorshift32(rng_stim);
      data     = rng_stim;
      run_access(PRV_M, WR, SIZE_WORD, adr, data, PASS, 1'b0, '0);
      run_access(PRV_M, RD, SIZE_WORD, adr, '0, PASS, 1'b1, data);
    end
    end_test();

    // 11223344 then AA in lane 1, BEEF in lanes 3:2 and CC in lane 0
    begin_test("byte lane merge");
    run_access(PRV_M, WR, SIZE_WORD, 32'h100, 32'h1122_3344, PASS, 1'b0, '0);
    run_access(PRV_M, WR, SIZE_BYTE, 32'h101, 32'h0000_AA00, PASS, 1'b0, '0);
    run_access(PRV_M, WR, SIZE_HALF, 32'h102, 32'hBEEF_0000, PASS, 1'b0, '0);
    run_access(PRV_M, WR, SIZE_BYTE, 32'h100, 32'h0000_00CC, PASS, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h100, '0, PASS, 1'b1, 32'hBEEF_AACC);
    end_test();

    begin_test("misaligned access");
    run_access(PRV_M, WR, SIZE_HALF, 32'h101, 32'h0012_3400, MISALIGN, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h102, '0, MISALIGN, 1'b0, '0);
    run_access(PRV_M, WR, SIZE_HALF, 32'h2001, 32'h0056_7800, PASS, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h2002, '0, PASS, 1'b0, '0);
    end_test();

    begin_test("region attributes");
    run_access(PRV_M, WR, SIZE_WORD, 32'h1000, 32'h5555_AAAA, REFUSE, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h3000, '0, REFUSE, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h1004, '0, PASS, 1'b1, fill_word(32'h1004));
    end_test();

    begin_test("privilege and lock");
    run_access(PRV_U, RD, SIZE_WORD, 32'h100, '0, PASS, 1'b1, 32'hBEEF_AACC);
    run_access(PRV_U, RD, SIZE_WORD, 32'h1004, '0, REFUSE, 1'b0, '0);
    run_access(PRV_U, WR, SIZE_WORD, 32'h2000, 32'h0BAD_0BAD, REFUSE, 1'b0, '0);
    run_access(PRV_S, RD, SIZE_WORD, 32'h104, '0, PASS, 1'b1, fill_word(32'h104));
    run_access(PRV_M, RD, SIZE_WORD, 32'h1008, '0, PASS, 1'b1, fill_word(32'h1008));
    run_access(PRV_M, WR, SIZE_WORD, 32'h2000, 32'h600D_600D, PASS, 1'b0, '0);
    run_access(PRV_M, WR, SIZE_WORD, 32'h2400, 32'h0BAD_0BAD, REFUSE, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h2400, '0, PASS, 1'b1, fill_word(32'h2400));
    end_test();

    begin_test("bus error");
    run_access(PRV_M, RD, SIZE_WORD, ERR_ADR, '0, BUS_ERR, 1'b0, '0);
    run_access(PRV_M, RD, SIZE_WORD, 32'h100, '0, PASS, 1'b1, 32'hBEEF_AACC);
    end_test();

    $display("summary: %0d tests run, %0d with errors, %0d errors in total",
             tests_run, failed_tests, errors);
    if (errors == 0 && failed_tests == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/dmem_pkg.sv
verilog/dmem_misaligned.sv
verilog/dmem_pmachk.sv
verilog/dmem_pmpchk.sv
verilog/dmem_nocache_core.sv
verilog/dmem_ctrl.sv
bench/tb_dmem_ctrl.sv

/* verilog/dmem_ctrl.sv */
// Data memory access block
`default_nettype none

module dmem_ctrl
  import dmem_pkg::*;
#(
  parameter int XLEN    = 32,
  parameter int PMA_CNT = 3,
  parameter int PMP_CNT = 4
)
(
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,

  // Static configuration
  input  wire pmacfg_t         pma_cfg_i [PMA_CNT],
  input  wire logic [XLEN-1:0] pma_adr_i [PMA_CNT],
  input  wire pmpcfg_t         pmp_cfg_i [PMP_CNT],
  input  wire logic [XLEN-1:0] pmp_adr_i [PMP_CNT],
  input  wire prv_t            prv_i,

  // CPU side
  input  wire logic            mem_req_i,
  input  wire logic [XLEN-1:0] mem_adr_i,
  input  wire size_t           mem_size_i,
  input  wire logic            mem_we_i,
  input  wire logic [XLEN-1:0] mem_d_i,
  input  wire logic            mem_lock_i,
  output logic      [XLEN-1:0] mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,

  // BIU side
  output logic                 biu_stb_o,
  input  wire logic            biu_stb_ack_i,
  output logic      [XLEN-1:0] biu_adri_o,
  output size_t                biu_size_o,
  output logic                 biu_we_o,
  output logic                 biu_lock_o,
  output prot_t                biu_prot_o,
  output logic      [XLEN-1:0] biu_d_o,
  input  wire logic [XLEN-1:0] biu_q_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i
);

  // Raw alignment result, before region attributes
  logic misaligned;
  logic pma_exception;
  logic pma_misaligned;
  logic pmp_exception;

  dmem_misaligned #(
    .XLEN ( XLEN ) )
  i_misaligned (
    .req_i        ( mem_req_i  ),
    .adr_i        ( mem_adr_i  ),
    .size_i       ( mem_size_i ),
    .misaligned_o ( misaligned ) );

  dmem_pmachk #(
    .XLEN    ( XLEN    ),
    .PMA_CNT ( PMA_CNT ) )
  i_pmachk (
    .pma_cfg_i    ( pma_cfg_i      ),
    .pma_adr_i    ( pma_adr_i      ),
    .req_i        ( mem_req_i      ),
    .adr_i        ( mem_adr_i      ),
    .we_i         ( mem_we_i       ),
    .misaligned_i ( misaligned     ),
    .exception_o  ( pma_exception  ),
    .misaligned_o ( pma_misaligned ) );

  dmem_pmpchk #(
    .XLEN    ( XLEN    ),
    .PMP_CNT ( PMP_CNT ) )
  i_pmpchk (
    .pmp_cfg_i   ( pmp_cfg_i     ),
    .pmp_adr_i   ( pmp_adr_i     ),
    .prv_i       ( prv_i         ),
    .req_i       ( mem_req_i     ),
    .adr_i       ( mem_adr_i     ),
    .we_i        ( mem_we_i      ),
    .exception_o ( pmp_exception ) );

  // CPU and BIU ports share their names with this level
  dmem_nocache_core #(
    .XLEN ( XLEN ) )
  i_core (
    .*,
    .misaligned_i    ( pma_misaligned ),
    .pma_exception_i ( pma_exception  ),
    .pmp_exception_i ( pmp_exception  ) );

endmodule

`default_nettype wire

/* verilog/dmem_misaligned.sv */
// Data access alignment check
`default_nettype none

module dmem_misaligned
  import dmem_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  wire logic            req_i,
  input  wire logic [XLEN-1:0] adr_i,
  input  wire size_t           size_i,
  output logic                 misaligned_o
);

  // Only the two low address bits matter for a 32-bit access
  always_comb
  begin
    if (!req_i)
    begin
      misaligned_o = 1'b0;
    end
    else
    begin
      case (size_i)
        SIZE_BYTE: misaligned_o = 1'b0;
        // Half must sit on an even address
        SIZE_HALF: misaligned_o = adr_i[0];
        SIZE_WORD: misaligned_o = |adr_i[1:0];
        // Unsupported size, never aligned
        default:   misaligned_o = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/dmem_nocache_core.sv */
// Uncached data transfer sequencer
`default_nettype none

module dmem_nocache_core
  import dmem_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,

  // CPU request and answer
  input  wire logic            mem_req_i,
  input  wire logic [XLEN-1:0] mem_adr_i,
  input  wire size_t           mem_size_i,
  input  wire logic            mem_we_i,
  input  wire logic [XLEN-1:0] mem_d_i,
  input  wire logic            mem_lock_i,
  input  wire prv_t            prv_i,
  input  wire logic            misaligned_i,
  input  wire logic            pma_exception_i,
  input  wire logic            pmp_exception_i,
  output logic      [XLEN-1:0] mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,

  // BIU port
  output logic                 biu_stb_o,
  input  wire logic            biu_stb_ack_i,
  output logic      [XLEN-1:0] biu_adri_o,
  output size_t                biu_size_o,
  output logic                 biu_we_o,
  output logic                 biu_lock_o,
  output prot_t                biu_prot_o,
  output logic      [XLEN-1:0] biu_d_o,
  input  wire logic [XLEN-1:0] biu_q_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_WAIT} state_t;

  state_t state;
  logic   accept;
  logic   refuse;

  // Answer cycle still sees the old request, skip it
  assign accept = (state == ST_IDLE) & mem_req_i & ~mem_ack_o & ~mem_err_o;
  assign refuse = misaligned_i | pma_exception_i | pmp_exception_i;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state            <= ST_IDLE;
      biu_stb_o        <= 1'b0;
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
    end
    else
    begin
      // Answers are single-cycle pulses
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
      case (state)
        ST_IDLE:
          if (accept && refuse)
          begin
            // Refused locally, bus untouched
            mem_err_o        <= 1'b1;
            mem_misaligned_o <= misaligned_i;
          end
          else if (accept)
          begin
            state     <= ST_STROBE;
            biu_stb_o <= 1'b1;
          end
        ST_STROBE:
          // Hold strobe through back-pressure
          if (biu_stb_ack_i)
          begin
            state     <= ST_WAIT;
            biu_stb_o <= 1'b0;
          end
        ST_WAIT:
          if (biu_ack_i || biu_err_i)
          begin
            state     <= ST_IDLE;
            mem_ack_o <= biu_ack_i;
            mem_err_o <= biu_err_i & ~biu_ack_i;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfer fields and read data

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      biu_adri_o <= mem_adr_i;
      biu_size_o <= mem_size_i;
      biu_we_o   <= mem_we_i;
      biu_lock_o <= mem_lock_i;
      biu_prot_o <= dmem_prot(prv_i);
      biu_d_o    <= mem_d_i;
    end
    if (state == ST_WAIT && biu_ack_i)
      mem_q_o <= biu_q_i;
  end

  // Stalled strobe keeps every field
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adri_o) &&
      $stable(biu_size_o) && $stable(biu_we_o) && $stable(biu_lock_o) &&
      $stable(biu_prot_o) && $stable(biu_d_o))
    else $error("BIU strobe fields changed under back-pressure");

  // One answer per access
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(mem_ack_o && mem_err_o))
    else $error("CPU ack and error raised together");

endmodule

`default_nettype wire

/* verilog/dmem_pkg.sv */
// Data memory access types
`default_nettype none

package dmem_pkg;

  // Transfer size, shared by CPU and bus ports
  typedef enum logic [1:0]
  {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_t;

  // RISC-V privilege levels, 2'b10 is reserved
  typedef enum logic [1:0]
  {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_t;

  // Bus protection, bit 0 data/instruction, bit 1 privileged/user, bit 2 spare
  typedef logic [2:0] prot_t;

  localparam prot_t PROT_DATA       = 3'b001;
  localparam prot_t PROT_USER       = 3'b000;
  localparam prot_t PROT_PRIVILEGED = 3'b010;

  // Attributes of one PMA region
  typedef struct packed
  {
    logic r;
    logic w;
    logic mis_ok;
  } pmacfg_t;

  // One PMP entry, TOR only
  typedef struct packed
  {
    logic l;
    logic rsvd;
    logic tor;
    logic w;
    logic r;
  } pmpcfg_t;

  // Data access protection for a privilege level
  function automatic prot_t dmem_prot(input prv_t prv);
    return PROT_DATA | ((prv == PRV_U) ? PROT_USER : PROT_PRIVILEGED);
  endfunction

endpackage

`default_nettype wire

/* verilog/dmem_pmachk.sv */
// Physical memory attribute check
`default_nettype none

module dmem_pmachk
  import dmem_pkg::*;
#(
  parameter int XLEN    = 32,
  parameter int PMA_CNT = 3
)
(
  input  wire pmacfg_t         pma_cfg_i [PMA_CNT],
  input  wire logic [XLEN-1:0] pma_adr_i [PMA_CNT],
  input  wire logic            req_i,
  input  wire logic [XLEN-1:0] adr_i,
  input  wire logic            we_i,
  input  wire logic            misaligned_i,
  output logic                 exception_o,
  output logic                 misaligned_o
);

  logic    region_hit;
  pmacfg_t region_attr;

  ////////////////////////////////////////////////////////////////////////////
  // Region lookup

  // Region i spans [bound i-1, bound i), lowest match wins
  always_comb
  begin : region_lookup
    logic [XLEN-1:0] lower;
    lower       = '0;
    region_hit  = 1'b0;
    region_attr = '0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (!region_hit && adr_i >= lower && adr_i < pma_adr_i[i])
      begin
        region_hit  = 1'b1;
        region_attr = pma_cfg_i[i];
      end
      // Upper bound becomes next region's base
      lower = pma_adr_i[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Verdicts

  // No region means no mis_ok either; request gating comes from the aligner
  assign misaligned_o = misaligned_i & ~region_attr.mis_ok;

  // Unmapped address, or direction not permitted
  assign exception_o = req_i & (~region_hit | (we_i ? ~region_attr.w : ~region_attr.r));

  // Idle CPU port never produces a PMA verdict
  always_comb
  begin
    assert final (req_i || (!exception_o && !misaligned_o))
      else $error("PMA verdict raised without a request");
  end

endmodule

`default_nettype wire

/* verilog/dmem_pmpchk.sv */
// Physical memory protection check
`default_nettype none

module dmem_pmpchk
  import dmem_pkg::*;
#(
  parameter int XLEN    = 32,
  parameter int PMP_CNT = 4
)
(
  input  wire pmpcfg_t         pmp_cfg_i [PMP_CNT],
  input  wire logic [XLEN-1:0] pmp_adr_i [PMP_CNT],
  input  wire prv_t            prv_i,
  input  wire logic            req_i,
  input  wire logic [XLEN-1:0] adr_i,
  input  wire logic            we_i,
  output logic                 exception_o
);

  logic    entry_hit;
  pmpcfg_t entry_cfg;
  logic    entry_perm;
  logic    allow;

  // Lowest enabled TOR entry covering the address
  always_comb
  begin : entry_lookup
    logic [XLEN-1:0] lower;
    lower     = '0;
    entry_hit = 1'b0;
    entry_cfg = '0;
    for (int i = 0; i < PMP_CNT; i++)
    begin
      if (!entry_hit && pmp_cfg_i[i].tor && adr_i >= lower && adr_i < pmp_adr_i[i])
      begin
        entry_hit = 1'b1;
        entry_cfg = pmp_cfg_i[i];
      end
      // TOR base comes from previous entry even when that one is off
      lower = pmp_adr_i[i];
    end
  end

  // Permission for this direction
  assign entry_perm = we_i ? entry_cfg.w : entry_cfg.r;

  always_comb
  begin
    if (prv_i == PRV_M)
      // Machine mode only bound by locked entries
      allow = ~(entry_hit & entry_cfg.l & ~entry_perm);
    else
      // User and supervisor need an explicit grant
      allow = entry_hit & entry_perm;
  end

  assign exception_o = req_i & ~allow;

  // Idle CPU port never produces a PMP fault
  always_comb
  begin
    assert final (req_i || !exception_o)
      else $error("PMP exception raised without a request");
  end

endmodule

`default_nettype wire
